//--- common/fetch_pkg.sv
// widths and codes assume a 64-bit bus carrying two 32-bit instructions per word, no compressed isa

package fetch_pkg;

  // ==========================================================================
  // widths with a meaning
  // ==========================================================================

  // byte address of an instruction or a bus word
  typedef logic [63:0] addr_t;

  // one beat on the read data channel
  typedef logic [63:0] word_t;

  // one uncompressed instruction
  typedef logic [31:0] inst_t;

  // read response code from the bus
  typedef logic [1:0]  resp_t;

  // ==========================================================================
  // constants
  // ==========================================================================

  // only okay is good, every other code counts as a bus error
  localparam resp_t RESP_OKAY = 2'b00;

  // major opcode of jal, bits 6:0 of the instruction
  localparam logic [6:0] OPCODE_JAL = 7'b1101111;

  // ==========================================================================
  // read state machine
  // ==========================================================================

  // idle offers an address, wait holds until the data beat
  typedef enum logic {
    FETCH_IDLE = 1'b0,
    FETCH_WAIT = 1'b1
  } fetch_state_e;

endpackage

//--- fetch/fetch_unit.sv
// one read in flight at a time; reset is synchronous and active high on rst_n; pc must be 4-aligned

module fetch_unit #(
  parameter fetch_pkg::addr_t RESET_VAL = 64'h8000_0000
) (
  input  logic              clk,
  input  logic              rst_n,

  // downstream back-pressure
  input  logic              pc_stall_i,

  // redirect from the jump resolver
  input  logic              redirect_i,
  input  fetch_pkg::addr_t  redirect_pc_i,

  // read address channel
  output logic              m_axi_arvalid_o,
  output fetch_pkg::addr_t  m_axi_araddr_o,
  input  logic              m_axi_arready_i,

  // read data channel
  input  logic              m_axi_rvalid_i,
  input  fetch_pkg::word_t  m_axi_rdata_i,
  input  fetch_pkg::resp_t  m_axi_rresp_i,
  output logic              m_axi_rready_o,

  // committed instruction towards decode
  output logic              commit_o,
  output fetch_pkg::addr_t  commit_pc_o,
  output fetch_pkg::inst_t  commit_inst_o,
  output logic              commit_err_o
);

  import fetch_pkg::*;

  fetch_state_e state_q;
  fetch_state_e state_d;

  // address of the read that is offered or outstanding
  addr_t        pc_q;

  // set when the outstanding response belongs to the old path
  logic         discard_q;

  logic         ar_fire;
  logic         r_fire;

  // ==========================================================================
  // bus strobes
  // ==========================================================================

  assign m_axi_arvalid_o = (state_q == FETCH_IDLE);

  // a redirect in the same cycle goes straight onto the bus
  assign m_axi_araddr_o  = redirect_i ? redirect_pc_i : pc_q;

  // stall keeps the data beat on the bus until decode can take it
  assign m_axi_rready_o  = (state_q == FETCH_WAIT) & ~pc_stall_i;

  assign ar_fire = m_axi_arvalid_o & m_axi_arready_i;
  assign r_fire  = m_axi_rvalid_i & m_axi_rready_o;

  // ==========================================================================
  // read state machine
  // ==========================================================================

  always_comb begin
    state_d = state_q;
    case (state_q)
      FETCH_IDLE: begin
        if (ar_fire) begin
          state_d = FETCH_WAIT;
        end
      end
      FETCH_WAIT: begin
        if (r_fire) begin
          state_d = FETCH_IDLE;
        end
      end
      default: begin
        state_d = FETCH_IDLE;
      end
    endcase
  end

  always_ff @(posedge clk) begin
    if (rst_n) begin
      state_q <= FETCH_IDLE;
    end else begin
      state_q <= state_d;
    end
  end

  // ==========================================================================
  // stale response tracking
  // ==========================================================================

  // a redirect arriving on the data beat drops that beat directly,
  // so the bit is only needed when the beat is still to come
  always_ff @(posedge clk) begin
    if (rst_n) begin
      discard_q <= 1'b0;
    end else if ((state_q == FETCH_WAIT) && redirect_i && !r_fire) begin
      discard_q <= 1'b1;
    end else if (r_fire) begin
      discard_q <= 1'b0;
    end
  end

  // ==========================================================================
  // program counter
  // ==========================================================================

  always_ff @(posedge clk) begin
    if (rst_n) begin
      pc_q <= RESET_VAL;
    end else if (redirect_i) begin
      pc_q <= redirect_pc_i;
    end else if (commit_o) begin
      pc_q <= pc_q + 64'd4;
    end
  end

  // ==========================================================================
  // commit
  // ==========================================================================

  assign commit_o      = r_fire & ~discard_q & ~redirect_i;
  assign commit_pc_o   = pc_q;

  // bit 2 picks the half of the 64-bit beat
  assign commit_inst_o = pc_q[2] ? m_axi_rdata_i[63:32] : m_axi_rdata_i[31:0];
  assign commit_err_o  = (m_axi_rresp_i != RESP_OKAY);

  // a commit closes the pending read, next cycle is back in idle
  commit_ends_wait: assert property (
    @(posedge clk) disable iff (rst_n)
    commit_o |=> (state_q == FETCH_IDLE)
  );

  // no second address while a read is outstanding
  no_ar_in_wait: assert property (
    @(posedge clk) disable iff (rst_n)
    (ar_fire || ((state_q == FETCH_WAIT) && !r_fire)) |=> !m_axi_arvalid_o
  );

endmodule

//--- design/jump_resolver.sv
// detects only jal; jalr and branches pass through untouched; reset is synchronous and active high

module jump_resolver (
  input  logic              clk,
  input  logic              rst_n,

  // downstream back-pressure
  input  logic              pc_stall_i,

  // committed instruction from fetch
  input  logic              commit_i,
  input  fetch_pkg::addr_t  commit_pc_i,
  input  fetch_pkg::inst_t  commit_inst_i,
  input  logic              commit_err_i,

  // redirect back to fetch
  output logic              redirect_o,
  output fetch_pkg::addr_t  redirect_pc_o,

  // decode stage outputs
  output logic              id_valid_o,
  output fetch_pkg::addr_t  id_pc_o,
  output fetch_pkg::inst_t  id_inst_o,
  output logic              id_err_o
);

  import fetch_pkg::*;

  logic  is_jal;
  addr_t jal_imm;
  addr_t jal_target;

  // ==========================================================================
  // decode stage register
  // ==========================================================================

  always_ff @(posedge clk) begin
    if (rst_n) begin
      id_valid_o <= 1'b0;
    end else if (!pc_stall_i) begin
      id_valid_o <= commit_i;
    end
  end

  // payload follows the valid bit and freezes under stall
  always_ff @(posedge clk) begin
    if (!pc_stall_i) begin
      id_pc_o   <= commit_pc_i;
      id_inst_o <= commit_inst_i;
      id_err_o  <= commit_err_i;
    end
  end

  // ==========================================================================
  // jal decode and target
  // ==========================================================================

  // a faulted fetch carries no real instruction
  assign is_jal = commit_i && !commit_err_i && (commit_inst_i[6:0] == OPCODE_JAL);

  // j-type immediate, imm[20|10:1|11|19:12], sign extended to 64 bits
  assign jal_imm = {{43{commit_inst_i[31]}},
                    commit_inst_i[31],
                    commit_inst_i[19:12],
                    commit_inst_i[20],
                    commit_inst_i[30:21],
                    1'b0};

  assign jal_target = commit_pc_i + jal_imm;

  // ==========================================================================
  // redirect pulse
  // ==========================================================================

  // commit already implies no stall, so the pulse is not held back
  always_ff @(posedge clk) begin
    if (rst_n) begin
      redirect_o <= 1'b0;
    end else begin
      redirect_o <= is_jal;
    end
  end

  always_ff @(posedge clk) begin
    if (is_jal) begin
      redirect_pc_o <= jal_target;
    end
  end

  // fetch cannot commit on back-to-back cycles
  redirect_single: assert property (
    @(posedge clk) disable iff (rst_n)
    redirect_o |=> !redirect_o
  );

  // the jump that caused the pulse sits in decode at the same time
  redirect_has_jal: assert property (
    @(posedge clk) disable iff (rst_n)
    redirect_o |-> (id_valid_o && (id_inst_o[6:0] == OPCODE_JAL))
  );

endmodule

//--- design/fetch_top.sv
// fetch front end: single outstanding read, jal-only redirect, sync active-high reset on rst_n

module fetch_top #(
  parameter fetch_pkg::addr_t RESET_VAL = 64'h8000_0000
) (
  input  logic              clk,
  input  logic              rst_n,

  // read address channel
  output logic              m_axi_arvalid_o,
  output fetch_pkg::addr_t  m_axi_araddr_o,
  input  logic              m_axi_arready_i,

  // read data channel
  input  logic              m_axi_rvalid_i,
  input  fetch_pkg::word_t  m_axi_rdata_i,
  input  fetch_pkg::resp_t  m_axi_rresp_i,
  output logic              m_axi_rready_o,

  // downstream
  input  logic              pc_stall_i,
  output logic              id_valid_o,
  output fetch_pkg::addr_t  id_pc_o,
  output fetch_pkg::inst_t  id_inst_o,
  output logic              id_err_o
);

  import fetch_pkg::*;

  // fetch to resolver
  logic  commit;
  addr_t commit_pc;
  inst_t commit_inst;
  logic  commit_err;

  // resolver back to fetch
  logic  redirect;
  addr_t redirect_pc;

  fetch_unit #(
    .RESET_VAL (RESET_VAL)
  ) fetch_i (
    .clk             (clk),
    .rst_n           (rst_n),
    .pc_stall_i      (pc_stall_i),
    .redirect_i      (redirect),
    .redirect_pc_i   (redirect_pc),
    .m_axi_arvalid_o (m_axi_arvalid_o),
    .m_axi_araddr_o  (m_axi_araddr_o),
    .m_axi_arready_i (m_axi_arready_i),
    .m_axi_rvalid_i  (m_axi_rvalid_i),
    .m_axi_rdata_i   (m_axi_rdata_i),
    .m_axi_rresp_i   (m_axi_rresp_i),
    .m_axi_rready_o  (m_axi_rready_o),
    .commit_o        (commit),
    .commit_pc_o     (commit_pc),
    .commit_inst_o   (commit_inst),
    .commit_err_o    (commit_err)
  );

  jump_resolver resolve_i (
    .clk           (clk),
    .rst_n         (rst_n),
    .pc_stall_i    (pc_stall_i),
    .commit_i      (commit),
    .commit_pc_i   (commit_pc),
    .commit_inst_i (commit_inst),
    .commit_err_i  (commit_err),
    .redirect_o    (redirect),
    .redirect_pc_o (redirect_pc),
    .id_valid_o    (id_valid_o),
    .id_pc_o       (id_pc_o),
    .id_inst_o     (id_inst_o),
    .id_err_o      (id_err_o)
  );

endmodule

//--- dv/axi_rom_model.sv
// one read at a time; slot contents depend only on the address; jal offsets are forward, 4 to 64

module axi_rom_model #(
  parameter logic [31:0] SEED = 32'ha649f056
) (
  input  logic              clk,
  input  logic              rst_n,

  // read address channel
  input  logic              arvalid_i,
  input  fetch_pkg::addr_t  araddr_i,
  output logic              arready_o,

  // read data channel
  output logic              rvalid_o,
  output fetch_pkg::word_t  rdata_o,
  output fetch_pkg::resp_t  rresp_o,
  input  logic              rready_i,

  // lookup port for the reference model
  input  fetch_pkg::addr_t  peek_addr_i,
  output fetch_pkg::inst_t  peek_inst_o,
  output logic              peek_jal_o,
  output fetch_pkg::addr_t  peek_off_o
);

  timeunit 1ns;
  timeprecision 1ps;

  import fetch_pkg::*;

  localparam logic [31:0] TAPS = 32'h8020_0003;

  logic [31:0] rng_q;
  logic        busy_q;
  addr_t       rd_addr_q;
  int          wait_q;

  function automatic logic [31:0] lfsr_next(input logic [31:0] s);
    if (s[0]) begin
      return (s >> 1) ^ TAPS;
    end
    return s >> 1;
  endfunction

  // 64 bits drawn from a state that mixes the whole address
  function automatic logic [63:0] slot_pool(input addr_t a);
    logic [31:0] s;
    logic [63:0] pool;
    s = SEED ^ (a[31:0] * 32'h9e37_79b1) ^ a[63:32];
    if (s == 32'd0) begin
      s = SEED;
    end
    pool = '0;
    for (int i = 0; i < 64; i++) begin
      s    = lfsr_next(s);
      pool = {pool[62:0], s[0]};
    end
    return pool;
  endfunction

  // pool[2:0] zero marks a jal, pool[6:3] its offset
  function automatic logic slot_jal(input addr_t a);
    logic [63:0] pool;
    pool = slot_pool(a);
    return (pool[2:0] == 3'd0);
  endfunction

  function automatic addr_t slot_off(input addr_t a);
    logic [63:0] pool;
    pool = slot_pool(a);
    return {58'd0, pool[6:3], 2'b00} + 64'd4;
  endfunction

  function automatic inst_t slot_inst(input addr_t a);
    logic [63:0] pool;
    addr_t       off;
    inst_t       inst;
    pool = slot_pool(a);
    off  = slot_off(a);
    if (slot_jal(a)) begin
      // j-type layout, rd taken from the pool
      inst = {off[20], off[10:1], off[11], off[19:12], pool[11:7], OPCODE_JAL};
    end else begin
      inst = pool[63:32];
      if (inst[6:0] == OPCODE_JAL) begin
        inst[4] = ~inst[4];
      end
    end
    return inst;
  endfunction

  task automatic draw(input int n, output logic [31:0] v);
    v = '0;
    for (int i = 0; i < n; i++) begin
      rng_q = lfsr_next(rng_q);
      v     = {v[30:0], rng_q[0]};
    end
  endtask

  assign peek_inst_o = slot_inst(peek_addr_i);
  assign peek_jal_o  = slot_jal(peek_addr_i);
  assign peek_off_o  = slot_off(peek_addr_i);

  initial begin
    rng_q     = SEED;
    busy_q    = 1'b0;
    rd_addr_q = '0;
    wait_q    = 0;
    arready_o = 1'b0;
    rvalid_o  = 1'b0;
    rdata_o   = '0;
    rresp_o   = RESP_OKAY;
  end

  // ==========================================================================
  // bus responder, sampled at the edge and driven 1 ns later
  // ==========================================================================

  always @(posedge clk) begin : respond
    logic [31:0] bits;
    logic        in_reset;
    logic        ar_fire;
    logic        r_fire;
    addr_t       addr_seen;
    addr_t       base;
    in_reset  = rst_n;
    ar_fire   = arvalid_i && arready_o;
    r_fire    = rvalid_o && rready_i;
    addr_seen = araddr_i;
    #1;
    if (in_reset) begin
      arready_o = 1'b0;
      rvalid_o  = 1'b0;
      busy_q    = 1'b0;
    end else begin
      if (r_fire) begin
        rvalid_o = 1'b0;
        busy_q   = 1'b0;
      end
      if (ar_fire) begin
        busy_q    = 1'b1;
        rd_addr_q = addr_seen;
        arready_o = 1'b0;
        draw(3, bits);
        wait_q    = bits;
      end
      if (busy_q && !rvalid_o) begin
        if (wait_q == 0) begin
          base     = {rd_addr_q[63:3], 3'b000};
          rvalid_o = 1'b1;
          rdata_o  = {slot_inst(base + 64'd4), slot_inst(base)};
          // slverr about one read in sixteen
          draw(4, bits);
          rresp_o  = (bits[3:0] == 4'd0) ? 2'b10 : RESP_OKAY;
        end else begin
          wait_q--;
        end
      end
      if (!busy_q) begin
        draw(1, bits);
        arready_o = bits[0];
      end
    end
  end

endmodule

//--- dv/fetch_tb.sv
// random stall and bus timing from a fixed seed; reset held high on rst_n for 10 cycles

module fetch_tb;

  timeunit 1ns;
  timeprecision 1ps;

  import fetch_pkg::*;

  localparam addr_t       RESET_VAL       = 64'h8000_0000;
  localparam logic [31:0] SEED            = 32'ha649f056;
  localparam logic [31:0] TAPS            = 32'h8020_0003;
  localparam int          NUM_INST        = 400;
  localparam int          CYCLES_PER_INST = 40;
  localparam int          RESET_CYCLES    = 10;
  localparam int          WATCHDOG_NS     = (NUM_INST * CYCLES_PER_INST + RESET_CYCLES) * 10;

  logic  clk;
  logic  rst_n;
  logic  pc_stall;
  logic  m_axi_arvalid;
  addr_t m_axi_araddr;
  logic  m_axi_arready;
  logic  m_axi_rvalid;
  word_t m_axi_rdata;
  resp_t m_axi_rresp;
  logic  m_axi_rready;
  logic  id_valid;
  addr_t id_pc;
  inst_t id_inst;
  logic  id_err;
  inst_t peek_inst;
  logic  peek_jal;
  addr_t peek_off;

  // reference model state
  addr_t       exp_pc;
  logic        after_jump;
  logic        err_map [addr_t];
  addr_t       last_ar;
  logic [31:0] rng;
  int          errors;
  int          consumed;
  int          jumps;
  int          bus_errs;
  int          upper_half;
  int          lower_half;

  // id outputs as seen at the previous edge
  logic        prev_stall;
  logic [1:0]  held_flags;
  addr_t       held_pc;
  inst_t       held_inst;

  fetch_top #(
    .RESET_VAL (RESET_VAL)
  ) dut_i (
    .clk             (clk),
    .rst_n           (rst_n),
    .m_axi_arvalid_o (m_axi_arvalid),
    .m_axi_araddr_o  (m_axi_araddr),
    .m_axi_arready_i (m_axi_arready),
    .m_axi_rvalid_i  (m_axi_rvalid),
    .m_axi_rdata_i   (m_axi_rdata),
    .m_axi_rresp_i   (m_axi_rresp),
    .m_axi_rready_o  (m_axi_rready),
    .pc_stall_i      (pc_stall),
    .id_valid_o      (id_valid),
    .id_pc_o         (id_pc),
    .id_inst_o       (id_inst),
    .id_err_o        (id_err)
  );

  axi_rom_model #(
    .SEED (SEED)
  ) rom_i (
    .clk         (clk),
    .rst_n       (rst_n),
    .arvalid_i   (m_axi_arvalid),
    .araddr_i    (m_axi_araddr),
    .arready_o   (m_axi_arready),
    .rvalid_o    (m_axi_rvalid),
    .rdata_o     (m_axi_rdata),
    .rresp_o     (m_axi_rresp),
    .rready_i    (m_axi_rready),
    .peek_addr_i (exp_pc),
    .peek_inst_o (peek_inst),
    .peek_jal_o  (peek_jal),
    .peek_off_o  (peek_off)
  );

  function automatic logic [31:0] lfsr_next(input logic [31:0] s);
    if (s[0]) begin
      return (s >> 1) ^ TAPS;
    end
    return s >> 1;
  endfunction

  task automatic draw(input int n, output logic [31:0] v);
    v = '0;
    for (int i = 0; i < n; i++) begin
      rng = lfsr_next(rng);
      v   = {v[30:0], rng[0]};
    end
  endtask

  task automatic report_mismatch(input string name, input logic [63:0] exp,
                                 input logic [63:0] act);
    errors++;
    $display("** Error %s: expected %h actual %h at %0t", name, exp, act, $time);
  endtask

  task automatic note_failure(input string what);
    errors++;
    $display("** Error: %s at %0t", what, $time);
  endtask

  task automatic print_summary();
    $display("consumed %0d, jumps %0d, bus errors %0d, upper %0d, lower %0d, errors %0d",
             consumed, jumps, bus_errs, upper_half, lower_half, errors);
  endtask

  // one instruction taken by the consumer
  task automatic check_consumed();
    logic exp_err;
    if (id_pc !== exp_pc) begin
      report_mismatch(after_jump ? "jump redirect" : "sequential fetch", exp_pc, id_pc);
    end
    if (id_inst !== peek_inst) begin
      report_mismatch("half select", peek_inst, id_inst);
    end
    exp_err = 1'b0;
    if (!err_map.exists(exp_pc)) begin
      note_failure("no data beat was ever returned for the expected pc");
    end else begin
      exp_err = err_map[exp_pc];
    end
    if (id_err !== exp_err) begin
      report_mismatch("bus error", exp_err, id_err);
    end
    if (exp_pc[2]) begin
      upper_half++;
    end else begin
      lower_half++;
    end
    if (exp_err) begin
      bus_errs++;
    end
    // a faulted jal falls through
    after_jump = peek_jal && !exp_err;
    if (after_jump) begin
      jumps++;
      exp_pc = exp_pc + peek_off;
    end else begin
      exp_pc = exp_pc + 64'd4;
    end
    consumed++;
  endtask

  // ==========================================================================
  // clock, reset and stall
  // ==========================================================================

  initial begin
    clk = 1'b0;
  end

  always #5 clk = ~clk;

  // stall about one cycle in four
  always @(posedge clk) begin : stall_drive
    logic [31:0] bits;
    logic        in_reset;
    in_reset = rst_n;
    #1;
    if (in_reset) begin
      pc_stall = 1'b0;
    end else begin
      draw(2, bits);
      pc_stall = (bits[1:0] == 2'b00);
    end
  end

  // ==========================================================================
  // monitor and checks
  // ==========================================================================

  always @(posedge clk) begin : monitor
    if (!rst_n) begin
      if (pc_stall && m_axi_rready) begin
        report_mismatch("stall rready", 64'd0, 64'd1);
      end
      if (prev_stall) begin
        if ({id_valid, id_err} !== held_flags) begin
          report_mismatch("stall hold", held_flags, {id_valid, id_err});
        end
        if (id_pc !== held_pc) begin
          report_mismatch("stall hold", held_pc, id_pc);
        end
        if (id_inst !== held_inst) begin
          report_mismatch("stall hold", held_inst, id_inst);
        end
      end
      if (id_valid && !pc_stall) begin
        check_consumed();
      end
      // bus traffic of this edge, recorded after the check above
      if (m_axi_arvalid && m_axi_arready) begin
        last_ar = m_axi_araddr;
      end
      if (m_axi_rvalid && m_axi_rready) begin
        err_map[last_ar] = (m_axi_rresp != RESP_OKAY);
      end
      prev_stall = pc_stall;
      held_flags = {id_valid, id_err};
      held_pc    = id_pc;
      held_inst  = id_inst;
    end
  end

  initial begin
    rst_n      = 1'b1;
    pc_stall   = 1'b0;
    rng        = SEED;
    exp_pc     = RESET_VAL;
    after_jump = 1'b0;
    last_ar    = '0;
    prev_stall = 1'b0;
    errors     = 0;
    consumed   = 0;
    jumps      = 0;
    bus_errs   = 0;
    upper_half = 0;
    lower_half = 0;
    repeat (RESET_CYCLES) @(posedge clk);
    #1;
    rst_n = 1'b0;
    @(posedge clk);
    if (m_axi_arvalid !== 1'b1) begin
      report_mismatch("reset state", 64'd1, m_axi_arvalid);
    end
    if (m_axi_araddr !== RESET_VAL) begin
      report_mismatch("reset state", RESET_VAL, m_axi_araddr);
    end
    if (id_valid !== 1'b0) begin
      report_mismatch("reset state", 64'd0, id_valid);
    end
    wait (consumed >= NUM_INST);
    @(posedge clk);
    if (upper_half == 0 || lower_half == 0) begin
      note_failure("only one half of the data word was ever used");
    end
    if (jumps == 0) begin
      note_failure("no jump was taken");
    end
    if (bus_errs == 0) begin
      note_failure("no bus error reached decode");
    end
    print_summary();
    if (errors == 0) begin
      $display("Testbench passed");
    end else begin
      $display("Testbench failed");
    end
    $finish;
  end

  // watchdog
  initial begin
    #(WATCHDOG_NS);
    note_failure($sformatf("watchdog expired after %0d consumed instructions", consumed));
    print_summary();
    $display("Testbench failed");
    $finish;
  end

endmodule

//--- compile.f
common/fetch_pkg.sv
fetch/fetch_unit.sv
design/jump_resolver.sv
design/fetch_top.sv
dv/axi_rom_model.sv
dv/fetch_tb.sv
